//--- all.f
logic/iwm_pkg.sv
logic/iwm_switches.sv
logic/motor_inertia.sv
logic/track_reader.sv
logic/iwm_read_core.sv
logic/iwm_disk.sv
+incdir+include
tests/tb_iwm_disk.sv

//--- tests/iwm_golden.txt
// Words 0-63 track bytes, word 64 track length in bits
// Then bus steps as kind addr data expected
// Kind 1 write, 2 write and check d_out, 3 read, 4 read and check, 0 end of group
// Track, sync FF between distinct nibbles
FF 96 FF 97 FF 9A FF 9B
FF 9D FF 9E FF 9F FF A6
FF A7 FF AB FF AC FF AD
FF AE FF AF FF B2 FF B3
FF B4 FF B5 FF B6 FF B7
FF B9 FF BA FF BB FF BC
FF BD FF BE FF BF FF CB
FF CD FF CE FF CF FF D3
// Bits on the track
0200
// Reset state, data register then status
4 D 00 00
4 D 00 80
4 C 00 80
0 0 00 00
// Mode register with motor off
4 D 00 00
4 D 00 80
2 F 1F 9F
4 E 00 FF
4 D 00 9F
// Motor on blocks the mode write
4 9 00 BF
4 D 00 BF
2 F 05 BF
4 E 00 FF
4 D 00 BF
4 8 00 9F
// Mode back to 00
2 F 00 80
4 E 00 FF
4 D 00 80
4 C 00 80
0 0 00 00
// Q7 set gives all ones
3 F 00 00
4 F 00 FF
4 D 00 FF
4 D 00 FF
2 E 00 FF
4 D 00 80
4 C 00 80
0 0 00 00

//--- include/iwm_tb_tasks.svh
// ==================================================
// Compare tasks and result counters for the IWM testbench
// Include inside the testbench module body
// ==================================================
`ifndef IWM_TB_TASKS_SVH
`define IWM_TB_TASKS_SVH

// Counts over the whole run
int unsigned total_checks;
int unsigned total_errors;
int unsigned tests_run;
int unsigned tests_failed;

// Counts for the test in progress
int unsigned test_checks;
int unsigned test_errors;

// Tally one check in the test and run counts
task automatic note_result(input bit ok);
    test_checks++;
    total_checks++;
    if (!ok) begin
        test_errors++;
        total_errors++;
    end
endtask

task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %0t ns %s: got %02h expected %02h", $time, what, got, exp);
    end
    note_result(got === exp);
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        $display("[FAIL] %0t ns %s: got %b expected %b", $time, what, got, exp);
    end
    note_result(got === exp);
endtask

task automatic check_state(input string what, input iwm_pkg::iwm_state_t got,
                           input iwm_pkg::iwm_state_t exp);
    if (got !== exp) begin
        $display("[FAIL] %0t ns %s: got %03h expected %03h", $time, what, got, exp);
    end
    note_result(got === exp);
endtask

task automatic check_addr(input string what, input iwm_pkg::trk_addr_t got,
                          input iwm_pkg::trk_addr_t exp);
    if (got !== exp) begin
        $display("[FAIL] %0t ns %s: got %04h expected %04h", $time, what, got, exp);
    end
    note_result(got === exp);
endtask

// Open a new test
task automatic start_test();
    test_checks = 0;
    test_errors = 0;
endtask

// One line per test
task automatic end_test(input int num, input string name);
    tests_run++;
    if (test_errors != 0) begin
        tests_failed++;
    end
    $display("TEST %0d %-24s %s (%0d checks, %0d errors)", num, name,
             (test_errors == 0) ? "PASS" : "FAIL", test_checks, test_errors);
endtask

`endif

//--- tests/tb_iwm_disk.sv
// ==================================================
// Testbench for the IWM disk controller
// Plays the golden bus steps and track image, then
// checks motor timing, byte framing and drive select
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module tb_iwm_disk;

    import iwm_pkg::*;

    localparam int HALF        = 10;
    localparam int SPINUP      = 40;
    localparam int SPINDOWN    = 100;
    localparam int TRACK_BYTES = 64;
    localparam int BITCNT_IDX  = 64;
    localparam int STEP_BASE   = 65;
    localparam int GOLD_WORDS  = 177;
    localparam int WRAP_BYTES  = 66;
    localparam int HOLD_CYCLES = 1500;
    localparam int unsigned RNG_SEED = 32'h4a83_4b79;

    // ==================================================
    // Test lengths in clocks, watchdog at twice the sum
    // ==================================================
    localparam int T_RESET  = 16;
    localparam int T_RESETS = 20;
    localparam int T_MODE   = 60;
    localparam int T_MOTOR  = 400;
    localparam int T_BYTES  = 30500;
    localparam int T_DRIVE  = 4000;
    localparam int T_UNUSED = 30;
    localparam int WATCHDOG_NS = 2 * 2 * HALF *
        (T_RESET + T_RESETS + T_MODE + T_MOTOR + T_BYTES + T_DRIVE + T_UNUSED);

    logic       CLK_14M;
    logic       RESET;
    cpu_bus_t   bus;
    logic       disk_ready;
    logic       write_protect;
    logic [7:0] track_data;
    bit_pos_t   track_bit_count;
    logic [7:0] d_out;
    trk_addr_t  track_addr;
    logic       floppy_motor_on;

    // Track bytes, length and bus steps
    logic [15:0] golden [0:GOLD_WORDS-1];
    trk_addr_t   addr_q;
    int          step_ptr;
    int          step_num;

    `include "iwm_tb_tasks.svh"

    iwm_disk #(
        .spinup_cycles   (SPINUP),
        .spindown_cycles (SPINDOWN)
    ) DUT (
        .CLK_14M         (CLK_14M),
        .RESET           (RESET),
        .bus             (bus),
        .disk_ready      (disk_ready),
        .write_protect   (write_protect),
        .track_data      (track_data),
        .track_bit_count (track_bit_count),
        .d_out           (d_out),
        .track_addr      (track_addr),
        .floppy_motor_on (floppy_motor_on)
    );

    initial begin
        CLK_14M = 1'b0;
        forever #HALF CLK_14M = ~CLK_14M;
    end

    // Track RAM, one clock of read latency
    always @(posedge CLK_14M) begin
        addr_q <= track_addr;
    end

    // Nothing is stored past the end of the track
    always @(negedge CLK_14M) begin
        track_data <= (addr_q < TRACK_BYTES) ? golden[addr_q][7:0] : 8'h00;
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic delay_in_window(input string what, input int n, input int lo, input int hi);
        bit ok;
        ok = (n >= lo) && (n <= hi);
        if (!ok) begin
            $display("%s took %0d clocks at %0t ns, allowed %0d to %0d", what, n, $time, lo, hi);
        end
        note_result(ok);
    endtask

    function automatic bit is_track_byte(input logic [7:0] b);
        bit found;
        found = 1'b0;
        for (int i = 0; i < TRACK_BYTES; i++) begin
            if (golden[i][7:0] === b) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic apply_reset();
        @(negedge CLK_14M);
        RESET = 1'b1;
        repeat (T_RESET) @(negedge CLK_14M);
        RESET = 1'b0;
    endtask

    // One access cycle, d_out taken just before the closing edge
    task automatic cpu_access(input logic rd, input logic [3:0] addr,
                              input logic [7:0] data, output logic [7:0] got);
        @(negedge CLK_14M);
        bus = {1'b1, rd, addr, data};
        #(HALF - 1);
        got = d_out;
        @(negedge CLK_14M);
        bus = '0;
    endtask

    // Runs golden steps up to the next end marker
    task automatic play_group();
        logic [3:0] kind;
        logic [3:0] addr;
        logic [7:0] data;
        logic [7:0] exp;
        logic [7:0] got;
        while (step_ptr + 3 < GOLD_WORDS && golden[step_ptr] != 16'h0000) begin
            kind = golden[step_ptr][3:0];
            addr = golden[step_ptr + 1][3:0];
            data = golden[step_ptr + 2][7:0];
            exp  = golden[step_ptr + 3][7:0];
            cpu_access(kind >= 4'd3, addr, data, got);
            if (kind == 4'd2 || kind == 4'd4) begin
                check_byte($sformatf("d_out step %0d addr %h", step_num, addr), got, exp);
            end
            step_ptr += 4;
            step_num++;
        end
        // Skip the end marker
        step_ptr += 4;
    endtask

    // Polls the data register and expects neither it nor the head to move
    task automatic data_hold(input string what, input int cycles);
        logic [7:0] held;
        logic [7:0] got;
        trk_addr_t  held_addr;
        int n;
        cpu_access(1'b1, 4'hC, 8'h00, held);
        held_addr = track_addr;
        n = 0;
        while (n < cycles) begin
            repeat (48) @(negedge CLK_14M);
            cpu_access(1'b1, 4'hC, 8'h00, got);
            check_byte(what, got, held);
            check_addr("track_addr held", track_addr, held_addr);
            n += 50;
        end
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        logic [7:0]  got;
        logic [7:0]  last;
        int          cycles;
        int          idx;
        int          polls;
        int          gap;
        int unsigned seed_val;
        bit          loaded;

        seed_val = $urandom(RNG_SEED);
        RESET         = 1'b1;
        bus           = '0;
        disk_ready    = 1'b1;
        write_protect = 1'b1;
        track_data    = 8'h00;
        addr_q        = '0;
        step_ptr      = STEP_BASE;
        step_num      = 0;
        $readmemh("tests/iwm_golden.txt", golden);
        track_bit_count = golden[BITCNT_IDX];
        loaded = (^golden[GOLD_WORDS - 1] !== 1'bx) && (track_bit_count == 16'd512);
        if (!loaded) begin
            $display("Golden file tests/iwm_golden.txt is missing or incomplete");
        end
        apply_reset();

        // Test 1, state right after reset
        start_test();
        note_result(loaded);
        check_bit("floppy_motor_on", floppy_motor_on, 1'b0);
        check_state("DUT.sw", DUT.sw, '0);
        check_addr("track_addr", track_addr, '0);
        play_group();
        end_test(1, "reset state");

        // Test 2, mode register write rule
        start_test();
        play_group();
        end_test(2, "mode register");

        // Test 3, inertia timing and sense
        start_test();
        // Let the short motor pulse of test 2 drain
        repeat (40) @(negedge CLK_14M);
        write_protect = 1'b0;
        cpu_access(1'b1, 4'hD, 8'h00, got);
        // Sense still forced high, motor bit from this access
        cpu_access(1'b1, 4'h9, 8'h00, got);
        check_byte("d_out status at motor on", got, 8'hA0);
        check_bit("d_out[5] at motor on", got[5], 1'b1);
        cycles = 0;
        while (!floppy_motor_on && cycles < 200) begin
            @(negedge CLK_14M);
            cycles++;
        end
        delay_in_window("floppy_motor_on rise", cycles, SPINUP, SPINUP + 3);
        cpu_access(1'b1, 4'hD, 8'h00, got);
        check_byte("d_out status wp 0", got, 8'h20);
        write_protect = 1'b1;
        cpu_access(1'b1, 4'hD, 8'h00, got);
        check_byte("d_out status wp 1", got, 8'hA0);
        write_protect = 1'b0;
        // Sense still follows the latched motor during this access
        cpu_access(1'b1, 4'h8, 8'h00, got);
        check_byte("d_out status at motor off", got, 8'h00);
        cycles = 0;
        while (floppy_motor_on && cycles < 300) begin
            @(negedge CLK_14M);
            cycles++;
        end
        delay_in_window("floppy_motor_on fall", cycles, SPINDOWN, SPINDOWN + 3);
        cpu_access(1'b1, 4'hD, 8'h00, got);
        check_byte("d_out status motor off", got, 8'h80);
        cpu_access(1'b1, 4'hC, 8'h00, got);
        end_test(3, "motor and sense");

        // Test 4, bytes framed from track byte 0 through the wrap
        start_test();
        apply_reset();
        cpu_access(1'b1, 4'h9, 8'h00, got);
        cycles = 0;
        while (!floppy_motor_on && cycles < 200) begin
            @(negedge CLK_14M);
            cycles++;
        end
        check_bit("floppy_motor_on before read", floppy_motor_on, 1'b1);
        last  = 8'h00;
        idx   = 0;
        polls = 0;
        // Gaps stay far below one byte time of 448 clocks
        while (idx < WRAP_BYTES && polls < 12000) begin
            gap = 1 + ($urandom % 40);
            repeat (gap) @(negedge CLK_14M);
            cpu_access(1'b1, 4'hC, 8'h00, got);
            polls++;
            check_bit("d_out is 00 or a track byte", (got === 8'h00) || is_track_byte(got),
                      1'b1);
            if (got !== last) begin
                check_byte($sformatf("d_out data byte %0d", idx), got,
                           golden[idx % TRACK_BYTES][7:0]);
                last = got;
                idx++;
            end
        end
        if (idx < WRAP_BYTES) begin
            $display("Byte stream stopped after %0d of %0d bytes", idx, WRAP_BYTES);
        end
        note_result(idx >= WRAP_BYTES);
        end_test(4, "byte decoding");

        // Test 5, drive 2 and a missing disk
        start_test();
        write_protect = 1'b0;
        cpu_access(1'b1, 4'hB, 8'h00, got);
        repeat (4) @(negedge CLK_14M);
        data_hold("d_out data drive 2", HOLD_CYCLES);
        cpu_access(1'b1, 4'hD, 8'h00, got);
        cpu_access(1'b1, 4'hD, 8'h00, got);
        check_byte("d_out status drive 2", got, 8'hA0);
        check_bit("d_out[7] drive 2", got[7], 1'b1);
        cpu_access(1'b1, 4'hC, 8'h00, got);
        cpu_access(1'b1, 4'hA, 8'h00, got);
        disk_ready = 1'b0;
        repeat (4) @(negedge CLK_14M);
        data_hold("d_out data no disk", HOLD_CYCLES);
        disk_ready = 1'b1;
        cpu_access(1'b1, 4'h8, 8'h00, got);
        cycles = 0;
        while (floppy_motor_on && cycles < 300) begin
            @(negedge CLK_14M);
            cycles++;
        end
        check_bit("floppy_motor_on after spin-down", floppy_motor_on, 1'b0);
        end_test(5, "drive 2 and no disk");

        // Test 6, registers behind Q7
        start_test();
        play_group();
        end_test(6, "unused registers");

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/iwm_disk.sv
// ==================================================
// IWM controller with one 5.25 inch WOZ drive
// Top level joining the CPU bus, the switch block, the
// spindle model, the track reader and the read side
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module iwm_disk #(
    parameter int unsigned spinup_cycles   = iwm_pkg::SPINUP_CLKS,
    parameter int unsigned spindown_cycles = iwm_pkg::SPINDOWN_CLKS
) (
    input  wire                       CLK_14M,
    input  wire                       RESET,
    input  wire iwm_pkg::cpu_bus_t    bus,
    input  wire                       disk_ready,
    input  wire                       write_protect,
    input  wire [7:0]                 track_data,
    input  wire iwm_pkg::bit_pos_t    track_bit_count,
    output wire [7:0]                 d_out,
    output wire iwm_pkg::trk_addr_t   track_addr,
    output wire                       floppy_motor_on
);

    import iwm_pkg::*;

    // Switch state shared by all blocks
    wire iwm_state_t sw;
    // One flux sample per bit cell
    wire flux_t      flux;
    wire             sense;

    iwm_switches u_switches (
        .CLK_14M (CLK_14M),
        .RESET   (RESET),
        .bus     (bus),
        .sw      (sw)
    );

    // Spindle output doubles as the motor-on line
    motor_inertia #(
        .spinup_cycles   (spinup_cycles),
        .spindown_cycles (spindown_cycles)
    ) u_motor (
        .CLK_14M  (CLK_14M),
        .RESET    (RESET),
        .sw       (sw),
        .spinning (floppy_motor_on)
    );

    track_reader u_reader (
        .CLK_14M         (CLK_14M),
        .RESET           (RESET),
        .sw              (sw),
        .spinning        (floppy_motor_on),
        .disk_ready      (disk_ready),
        .write_protect   (write_protect),
        .track_data      (track_data),
        .track_bit_count (track_bit_count),
        .track_addr      (track_addr),
        .flux            (flux),
        .sense           (sense)
    );

    iwm_read_core u_read (
        .CLK_14M (CLK_14M),
        .RESET   (RESET),
        .bus     (bus),
        .sw      (sw),
        .flux    (flux),
        .sense   (sense),
        .d_out   (d_out)
    );

endmodule

`default_nettype wire

//--- logic/iwm_read_core.sv
// ==================================================
// IWM read side
// Frames flux cells into bytes, holds the data register
// and returns the register picked by Q7/Q6 on d_out
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module iwm_read_core (
    input  wire                     CLK_14M,
    input  wire                     RESET,
    input  wire iwm_pkg::cpu_bus_t  bus,
    input  wire iwm_pkg::iwm_state_t sw,
    input  wire iwm_pkg::flux_t     flux,
    input  wire                     sense,
    output logic [7:0]              d_out
);

    import iwm_pkg::*;

    // ==================================================
    // Byte framing
    // ==================================================
    logic [7:0] shift_reg;
    logic [7:0] shift_next;
    logic [7:0] data_reg;

    // New bit enters at the LSB
    assign shift_next = {shift_reg[6:0], flux.flux};

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            shift_reg <= '0;
            data_reg  <= '0;
        end else if (flux.cell_end) begin
            if (shift_next[7]) begin
                // A set MSB marks a whole nibble
                data_reg  <= shift_next;
                shift_reg <= '0;
            end else begin
                shift_reg <= shift_next;
            end
        end
    end

    // ==================================================
    // Register read
    // ==================================================
    reg_sel_e   reg_sel;
    logic [7:0] status_byte;
    logic [7:0] reg_mux;

    // Latched Q7/Q6 choose the register
    assign reg_sel = reg_sel_e'({sw.q7, sw.q6});

    // Sense, spare zero, motor, then mode
    assign status_byte = {sense, 1'b0, sw.imm_motor, sw.imm_mode};

    always_comb begin
        unique case (reg_sel)
            READ_DATA: begin
                // Data stays until the next byte arrives
                reg_mux = data_reg;
            end
            READ_STATUS: begin
                reg_mux = status_byte;
            end
            READ_HANDSHAKE, READ_MODE_WR: begin
                // No write path behind these
                reg_mux = ALL_ONES_BYTE;
            end
        endcase
    end

    // Bus is driven only while the device is selected
    assign d_out = bus.dev_sel ? reg_mux : 8'h00;

endmodule

`default_nettype wire

//--- logic/track_reader.sv
// ==================================================
// Head of drive 1 over a WOZ track held in byte RAM
// Times bit cells, walks the bit position around the
// track and turns each cell into one flux sample
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module track_reader (
    input  wire                     CLK_14M,
    input  wire                     RESET,
    input  wire iwm_pkg::iwm_state_t sw,
    input  wire                     spinning,
    input  wire                     disk_ready,
    input  wire                     write_protect,
    input  wire [7:0]               track_data,
    input  wire iwm_pkg::bit_pos_t  track_bit_count,
    output iwm_pkg::trk_addr_t      track_addr,
    output iwm_pkg::flux_t          flux,
    output logic                    sense
);

    import iwm_pkg::*;

    localparam logic [CELL_CNT_W-1:0] CELL_LAST = CELL_CNT_W'(BIT_CELL_CLKS - 1);

    logic                  enable;
    logic [CELL_CNT_W-1:0] cell_cnt;
    bit_pos_t              bit_pos;
    logic [16:0]           pos_inc;
    logic                  pos_wrap;
    logic                  cur_bit;

    // Drive 2 is an empty slot
    assign enable = spinning && disk_ready && !sw.drive_sel;

    // Wrap at the track length
    assign pos_inc  = {1'b0, bit_pos} + 17'd1;
    assign pos_wrap = pos_inc >= {1'b0, track_bit_count};

    // Byte address, RAM answers one clock later
    assign track_addr = bit_pos[15:3];
    // MSB of each byte goes first
    assign cur_bit    = track_data[3'd7 - bit_pos[2:0]];

    // ==================================================
    // Cell timer and head position
    // ==================================================
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            cell_cnt      <= '0;
            bit_pos       <= '0;
            flux.cell_end <= 1'b0;
            flux.flux     <= 1'b0;
        end else begin
            flux.cell_end <= 1'b0;
            if (enable) begin
                if (cell_cnt == CELL_LAST) begin
                    cell_cnt      <= '0;
                    flux.cell_end <= 1'b1;
                    flux.flux     <= cur_bit;
                    bit_pos       <= pos_wrap ? '0 : pos_inc[15:0];
                end else begin
                    cell_cnt <= cell_cnt + 1'b1;
                end
            end
        end
    end

    // Sense is pulled high unless drive 1 is running
    assign sense = (sw.drive_on && !sw.drive_sel) ? write_protect : 1'b1;

endmodule

`default_nettype wire

//--- logic/motor_inertia.sv
// ==================================================
// Spindle inertia of the 5.25 inch drive
// Delays the motor switch by a spin-up period on and a
// spin-down period off. Its output is the motor-on line
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module motor_inertia #(
    parameter int unsigned spinup_cycles   = iwm_pkg::SPINUP_CLKS,
    parameter int unsigned spindown_cycles = iwm_pkg::SPINDOWN_CLKS
) (
    input  wire                     CLK_14M,
    input  wire                     RESET,
    input  wire iwm_pkg::iwm_state_t sw,
    output logic                    spinning
);

    import iwm_pkg::*;

    localparam logic [MOTOR_CNT_W-1:0] SPINUP_CNT   = MOTOR_CNT_W'(spinup_cycles);
    localparam logic [MOTOR_CNT_W-1:0] SPINDOWN_CNT = MOTOR_CNT_W'(spindown_cycles);

    logic [MOTOR_CNT_W-1:0] motor_cnt;
    // Set once spin-up has finished in this motor-on period
    logic                   spinup_done;

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            motor_cnt   <= '0;
            spinup_done <= 1'b0;
            spinning    <= 1'b0;
        end else if (sw.drive_on) begin
            if (!spinup_done) begin
                // Count up toward full speed
                if (motor_cnt >= SPINUP_CNT) begin
                    spinning    <= 1'b1;
                    spinup_done <= 1'b1;
                    motor_cnt   <= SPINDOWN_CNT;
                end else begin
                    motor_cnt <= motor_cnt + 1'b1;
                end
            end else begin
                // At speed, hold the spin-down preload
                spinning  <= 1'b1;
                motor_cnt <= SPINDOWN_CNT;
            end
        end else begin
            // Coasting down
            spinup_done <= 1'b0;
            if (motor_cnt != '0) begin
                motor_cnt <= motor_cnt - 1'b1;
            end else begin
                spinning <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/iwm_switches.sv
// ==================================================
// IWM soft switch latches and mode register
// Any access latches addr[0] into the switch chosen by
// addr[3:1]. Also gives the motor and mode values as seen
// after the current access, for same-cycle status reads
// ==================================================
`timescale 1ns/1ns
`default_nettype none

module iwm_switches (
    input  wire                  CLK_14M,
    input  wire                  RESET,
    input  wire iwm_pkg::cpu_bus_t bus,
    output iwm_pkg::iwm_state_t  sw
);

    import iwm_pkg::*;

    // ==================================================
    // Access decode
    // ==================================================
    sw_off_e           sw_off;
    logic              access;
    logic              wr_access;

    // Latched switch state
    logic              drive_on;
    logic              drive_sel;
    logic              q6;
    logic              q7;
    logic [MODE_W-1:0] mode_reg;

    // Values after this access
    logic              next_q6;
    logic              next_q7;
    logic              next_motor;
    logic              mode_wr;

    assign access    = bus.dev_sel;
    assign wr_access = bus.dev_sel && !bus.rd;
    assign sw_off    = sw_off_e'(bus.addr[3:1]);

    // New Q6/Q7 count for the mode write in the same access
    assign next_q6    = (access && sw_off == Q6_SW) ? bus.addr[0] : q6;
    assign next_q7    = (access && sw_off == Q7_SW) ? bus.addr[0] : q7;
    assign next_motor = (access && sw_off == MOTOR) ? bus.addr[0] : drive_on;

    // Mode write needs motor off, Q6=Q7=1 and an odd address
    assign mode_wr = wr_access && !drive_on && next_q6 && next_q7 && bus.addr[0];

    // ==================================================
    // Switch latches
    // ==================================================
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            drive_on  <= 1'b0;
            drive_sel <= 1'b0;
            q6        <= 1'b0;
            q7        <= 1'b0;
            mode_reg  <= '0;
        end else if (access) begin
            unique case (sw_off)
                PHASE0, PHASE1, PHASE2, PHASE3: begin
                    // Head is fixed on one track
                    // so the phase lines go nowhere
                end
                MOTOR: begin
                    drive_on <= bus.addr[0];
                end
                DRIVE_SEL: begin
                    drive_sel <= bus.addr[0];
                end
                Q6_SW: begin
                    q6 <= bus.addr[0];
                end
                Q7_SW: begin
                    q7 <= bus.addr[0];
                end
            endcase

            // Only the low 5 mode bits exist
            if (mode_wr) begin
                mode_reg <= bus.data[MODE_W-1:0];
            end
        end
    end

    // ==================================================
    // State out
    // ==================================================
    always_comb begin
        sw.drive_on  = drive_on;
        sw.drive_sel = drive_sel;
        sw.q6        = q6;
        sw.q7        = q7;
        sw.imm_motor = next_motor;
        // Status sees the new mode during the write itself
        sw.imm_mode  = mode_wr ? bus.data[MODE_W-1:0] : mode_reg;
    end

endmodule

`default_nettype wire

//--- logic/iwm_pkg.sv
// ==================================================
// Shared types and constants of the IWM disk block
// Bus struct, switch and register encodings, drive state
// and the timing constants for a 14 MHz clock
// ==================================================
`default_nettype none

package iwm_pkg;

    // ==================================================
    // Timing at 14 MHz
    // ==================================================
    // One 4 us bit cell
    localparam int unsigned BIT_CELL_CLKS = 56;
    // About 300 ms spin-up and 1 s spin-down
    localparam int unsigned SPINUP_CLKS   = 4_200_000;
    localparam int unsigned SPINDOWN_CLKS = 14_000_000;

    // Counter and field widths
    localparam int MOTOR_CNT_W = 24;
    localparam int CELL_CNT_W  = 6;
    localparam int MODE_W      = 5;

    // Returned by the handshake and write-mode registers
    localparam logic [7:0] ALL_ONES_BYTE = 8'hFF;

    // CPU side access, one cycle per access
    typedef struct packed {
        logic       dev_sel;
        logic       rd;
        logic [3:0] addr;
        logic [7:0] data;
    } cpu_bus_t;

    // Soft switch index taken from addr[3:1]
    typedef enum logic [2:0] {
        PHASE0    = 3'd0,
        PHASE1    = 3'd1,
        PHASE2    = 3'd2,
        PHASE3    = 3'd3,
        MOTOR     = 3'd4,
        DRIVE_SEL = 3'd5,
        Q6_SW     = 3'd6,
        Q7_SW     = 3'd7
    } sw_off_e;

    // Read register picked by {Q7, Q6}
    typedef enum logic [1:0] {
        READ_DATA      = 2'b00,
        READ_STATUS    = 2'b01,
        READ_HANDSHAKE = 2'b10,
        READ_MODE_WR   = 2'b11
    } reg_sel_e;

    // Latched switches plus the view after the current access
    typedef struct packed {
        logic              drive_on;
        logic              drive_sel;
        logic              q6;
        logic              q7;
        logic              imm_motor;
        logic [MODE_W-1:0] imm_mode;
    } iwm_state_t;

    // One bit cell from the drive
    typedef struct packed {
        logic cell_end;
        logic flux;
    } flux_t;

    typedef logic [15:0] bit_pos_t;
    typedef logic [12:0] trk_addr_t;

endpackage

`default_nettype wire
